// ==== writeback_top.f ====
design/cdb_pkg.sv
design/scalu.sv
design/csr_unit.sv
design/cdb_slot.sv
design/cdb_arbiter.sv
design/writeback_top.sv
bench/writeback_properties.sv
bench/writeback_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the writeback stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module writeback_tb \
  -f writeback_top.f \
  -o writeback_sim

./obj_dir/writeback_sim

// ==== bench/writeback_tb.sv ====
/* writeback stage testbench */
module writeback_tb
  import cdb_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CSR      = 4;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_ALU_OPS  = 24;
  // roughly two cycles per issue plus the multi-source tests
  localparam int TEST_CYCLES  = RESET_CYCLES + 2 * (NUM_ALU_OPS + 4) + 70;
  localparam int MAX_CYCLES   = 2 * TEST_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        rename_valid;
  rename_pkt_t rename_pkt;
  logic        alu0_valid;
  alu_issue_t  alu0_issue;
  logic        alu0_stall;
  logic        alu1_valid;
  alu_issue_t  alu1_issue;
  logic        alu1_stall;
  logic        csr_valid;
  csr_issue_t  csr_issue;
  logic        mc0_valid;
  cdb_pkt_t    mc0_pkt;
  logic        mc0_stall;
  logic        mc1_valid;
  cdb_pkt_t    mc1_pkt;
  logic        mc1_stall;
  logic        lsq_valid;
  cdb_pkt_t    lsq_pkt;
  logic        lsq_stall;
  logic        cdb_valid;
  cdb_pkt_t    cdb_pkt;

  logic [XLEN-1:0] csr_model [NUM_CSR];
  int              cycles;

  writeback_top #(.NUM_CSR(NUM_CSR)) u_dut (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run exceeded %0d cycles without finishing", MAX_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // expected bus packet per the operation rules
  function automatic cdb_pkt_t alu_model(input alu_issue_t iss);
    cdb_pkt_t p;
    longint   sa;
    longint   sb;
    longint   wide;
    p       = '0;
    p.robid = iss.robid;
    p.rd    = iss.rd;
    sa      = longint'($signed(iss.a));
    sb      = longint'($signed(iss.b));
    wide    = 0;
    case (iss.op)
      ADD: wide = sa + sb;
      SUB: wide = sa - sb;
      AND: p.result = iss.a & iss.b;
      OR:  p.result = iss.a | iss.b;
      XOR: p.result = iss.a ^ iss.b;
      SLT: p.result = (sa < sb) ? 32'd1 : 32'd0;
      SLL: p.result = iss.a << iss.b[4:0];
      default: p.result = iss.a >> iss.b[4:0];
    endcase
    if (iss.op == ADD || iss.op == SUB) begin
      p.result = 32'(wide);
      if (wide > 64'sh7fffffff || wide < -64'sh80000000) begin
        p.error  = 1'b1;
        p.ecause = ECAUSE_OVERFLOW;
      end
    end
    return p;
  endfunction

  function automatic cdb_pkt_t rename_model(input rename_pkt_t r);
    cdb_pkt_t p;
    p        = '0;
    p.robid  = r.robid;
    p.rd     = {1'b0, r.rd};
    p.result = {r.addr, 2'b00};
    return p;
  endfunction

  function automatic alu_issue_t rand_issue();
    alu_issue_t iss;
    iss.op    = alu_op_e'(3'($urandom_range(7)));
    iss.robid = 7'($urandom());
    iss.rd    = 6'($urandom());
    iss.a     = $urandom();
    iss.b     = $urandom();
    return iss;
  endfunction

  function automatic cdb_pkt_t rand_pkt();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return cdb_pkt_t'(r[50:0]);
  endfunction

  function automatic rename_pkt_t rand_rename();
    rename_pkt_t r;
    r.robid = 7'($urandom());
    r.rd    = 5'($urandom());
    r.addr  = 30'($urandom());
    return r;
  endfunction

  // lsq in the top bit, alu1 in bit 0
  function automatic logic [4:0] stall_vec();
    return {lsq_stall, mc0_stall, mc1_stall, alu0_stall, alu1_stall};
  endfunction

  task automatic idle_all();
    rename_valid <= 1'b0;
    alu0_valid   <= 1'b0;
    alu1_valid   <= 1'b0;
    csr_valid    <= 1'b0;
    mc0_valid    <= 1'b0;
    mc1_valid    <= 1'b0;
    lsq_valid    <= 1'b0;
  endtask

  task automatic issue_alu(input int unit, input alu_issue_t iss);
    @(posedge clk);
    if (unit == 0) begin
      alu0_valid <= 1'b1;
      alu0_issue <= iss;
    end else begin
      alu1_valid <= 1'b1;
      alu1_issue <= iss;
    end
    @(posedge clk);
    idle_all();
    @(negedge clk);
    check_value("cdb_valid", 64'(cdb_valid), 64'(1));
    check_value("cdb_pkt", 64'(cdb_pkt), 64'(alu_model(iss)));
  endtask

  task automatic issue_csr(input csr_issue_t ci);
    cdb_pkt_t exp;
    exp       = '0;
    exp.robid = ci.robid;
    exp.rd    = ci.rd;
    if (ci.addr < NUM_CSR) begin
      exp.result = csr_model[ci.addr[1:0]];
      if (ci.write) begin
        csr_model[ci.addr[1:0]] = ci.wdata;
      end
    end else begin
      exp.error  = 1'b1;
      exp.ecause = ECAUSE_ILLEGAL_CSR;
    end
    @(posedge clk);
    csr_valid <= 1'b1;
    csr_issue <= ci;
    @(posedge clk);
    idle_all();
    @(negedge clk);
    check_value("cdb_valid", 64'(cdb_valid), 64'(1));
    check_value("cdb_pkt", 64'(cdb_pkt), 64'(exp));
  endtask

  task automatic test_alu_ops();
    alu_issue_t iss;
    for (int n = 0; n < NUM_ALU_OPS; n++) begin
      issue_alu(n % 2, rand_issue());
    end
    // signed overflow corners
    iss    = rand_issue();
    iss.op = ADD;
    iss.a  = 32'h7fff_ffff;
    iss.b  = 32'h0000_0001;
    issue_alu(0, iss);
    iss.a  = 32'h8000_0000;
    iss.b  = 32'hffff_ffff;
    issue_alu(1, iss);
    iss.op = SUB;
    iss.a  = 32'h8000_0000;
    iss.b  = 32'h0000_0001;
    issue_alu(0, iss);
    iss.a  = 32'hffff_ffff;
    iss.b  = 32'h7fff_ffff;
    issue_alu(1, iss);
  endtask

  task automatic test_priority();
    cdb_pkt_t    exp [6];
    alu_issue_t  i0;
    alu_issue_t  i1;
    rename_pkt_t r;
    logic [4:0]  exp_stall;
    i0     = rand_issue();
    i1     = rand_issue();
    r      = rand_rename();
    exp[0] = rename_model(r);
    exp[1] = rand_pkt();
    exp[2] = rand_pkt();
    exp[3] = rand_pkt();
    exp[4] = alu_model(i0);
    exp[5] = alu_model(i1);
    @(posedge clk);
    rename_valid <= 1'b1;
    rename_pkt   <= r;
    lsq_valid    <= 1'b1;
    lsq_pkt      <= exp[1];
    mc0_valid    <= 1'b1;
    mc0_pkt      <= exp[2];
    mc1_valid    <= 1'b1;
    mc1_pkt      <= exp[3];
    alu0_valid   <= 1'b1;
    alu0_issue   <= i0;
    alu1_valid   <= 1'b1;
    alu1_issue   <= i1;
    @(posedge clk);
    idle_all();
    for (int k = 0; k < 6; k++) begin
      @(negedge clk);
      // slot j still waits until its own bus cycle j+1
      for (int j = 0; j < 5; j++) begin
        exp_stall[4-j] = (j >= k);
      end
      check_value("cdb_valid", 64'(cdb_valid), 64'(1));
      check_value("cdb_pkt", 64'(cdb_pkt), 64'(exp[k]));
      check_value("stalls", 64'(stall_vec()), 64'(exp_stall));
    end
    @(negedge clk);
    check_value("cdb_valid", 64'(cdb_valid), 64'(0));
  endtask

  task automatic test_rename_preempt();
    rename_pkt_t r;
    cdb_pkt_t    lp;
    r    = rand_rename();
    r.rd = 5'h1f;
    lp   = rand_pkt();
    @(posedge clk);
    rename_valid <= 1'b1;
    rename_pkt   <= r;
    lsq_valid    <= 1'b1;
    lsq_pkt      <= lp;
    @(posedge clk);
    idle_all();
    @(negedge clk);
    check_value("cdb_pkt", 64'(cdb_pkt), 64'(rename_model(r)));
    check_value("cdb_pkt.rd[5]", 64'(cdb_pkt.rd[5]), 64'(0));
    check_value("cdb_pkt.result[1:0]", 64'(cdb_pkt.result[1:0]), 64'(0));
    check_value("cdb_pkt.error", 64'(cdb_pkt.error), 64'(0));
    check_value("lsq_stall", 64'(lsq_stall), 64'(1));
    @(negedge clk);
    check_value("cdb_pkt", 64'(cdb_pkt), 64'(lp));
    check_value("lsq_stall", 64'(lsq_stall), 64'(0));
  endtask

  task automatic test_csr();
    csr_issue_t ci;
    ci = '{write: 1'b1, addr: 8'd2, wdata: $urandom(), robid: 7'd5, rd: 6'd12};
    issue_csr(ci);
    ci.wdata = $urandom();
    issue_csr(ci);
    ci.write = 1'b0;
    issue_csr(ci);
    // aliases register 2 in the low address bits
    ci.write = 1'b1;
    ci.addr  = 8'd6;
    ci.wdata = ~ci.wdata;
    issue_csr(ci);
    ci.write = 1'b0;
    for (int a = 0; a < NUM_CSR; a++) begin
      ci.addr = 8'(a);
      issue_csr(ci);
    end
  endtask

  task automatic test_flush();
    csr_issue_t ci;
    ci = '{write: 1'b1, addr: 8'd1, wdata: 32'hdead_beef, robid: 7'd9, rd: 6'd9};
    @(posedge clk);
    rename_valid <= 1'b1;
    rename_pkt   <= rand_rename();
    lsq_valid    <= 1'b1;
    lsq_pkt      <= rand_pkt();
    mc0_valid    <= 1'b1;
    mc0_pkt      <= rand_pkt();
    alu1_valid   <= 1'b1;
    alu1_issue   <= rand_issue();
    @(posedge clk);
    idle_all();
    flush     <= 1'b1;
    csr_valid <= 1'b1;
    csr_issue <= ci;
    @(negedge clk);
    check_value("cdb_valid", 64'(cdb_valid), 64'(1));
    @(posedge clk);
    flush     <= 1'b0;
    csr_valid <= 1'b0;
    @(negedge clk);
    check_value("cdb_valid", 64'(cdb_valid), 64'(0));
    check_value("stalls", 64'(stall_vec()), 64'(0));
    // register 1 must still hold its old value
    ci.write = 1'b0;
    issue_csr(ci);
  endtask

  task automatic test_stall_hold();
    cdb_pkt_t lp;
    cdb_pkt_t first;
    cdb_pkt_t second;
    lp     = rand_pkt();
    first  = rand_pkt();
    second = rand_pkt();
    @(posedge clk);
    lsq_valid <= 1'b1;
    lsq_pkt   <= lp;
    mc0_valid <= 1'b1;
    mc0_pkt   <= first;
    @(posedge clk);
    lsq_valid <= 1'b0;
    mc0_pkt   <= second;
    @(negedge clk);
    check_value("cdb_pkt", 64'(cdb_pkt), 64'(lp));
    check_value("mc0_stall", 64'(mc0_stall), 64'(1));
    while (mc0_stall) begin
      @(negedge clk);
    end
    check_value("cdb_pkt", 64'(cdb_pkt), 64'(first));
    @(posedge clk);
    mc0_valid <= 1'b0;
    @(negedge clk);
    check_value("cdb_valid", 64'(cdb_valid), 64'(1));
    check_value("cdb_pkt", 64'(cdb_pkt), 64'(second));
  endtask

  initial begin
    void'($urandom(32'h0c586689));
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    rename_valid = 1'b0;
    rename_pkt   = '0;
    alu0_valid   = 1'b0;
    alu0_issue   = '0;
    alu1_valid   = 1'b0;
    alu1_issue   = '0;
    csr_valid    = 1'b0;
    csr_issue    = '0;
    mc0_valid    = 1'b0;
    mc0_pkt      = '0;
    mc1_valid    = 1'b0;
    mc1_pkt      = '0;
    lsq_valid    = 1'b0;
    lsq_pkt      = '0;
    cycles       = 0;
    for (int i = 0; i < NUM_CSR; i++) begin
      csr_model[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("cdb_valid", 64'(cdb_valid), 64'(0));
    check_value("stalls", 64'(stall_vec()), 64'(0));
    test_alu_ops();
    test_priority();
    test_rename_preempt();
    test_csr();
    test_flush();
    test_stall_hold();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== bench/writeback_properties.sv ====
/* writeback stage assertions */
module writeback_properties
  import cdb_pkg::*;
(
  input logic                 clk,
  input logic                 rst_n,
  input logic                 flush,
  input logic                 rename_valid,
  input logic                 csr_valid,
  input logic                 alu0_valid,
  input logic                 cdb_valid,
  input logic [NUM_SLOTS-1:0] slot_valid,
  input logic [NUM_SLOTS-1:0] slot_stall,
  input cdb_pkt_t             slot_pkt [NUM_SLOTS]
);

  timeunit 1ns;
  timeprecision 100ps;

  // issue never targets the shared slot twice
  a_csr_alu0_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_valid && alu0_valid))
    else $error("csr_valid and alu0_valid high in the same cycle");

  for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_hold
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      slot_stall[i] |=> $stable(slot_pkt[i]))
      else $error("slot %0d packet changed while stalled", i);
  end

  a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !cdb_valid)
    else $error("cdb_valid high in the cycle after flush");

  a_slot_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (|slot_valid) |-> cdb_valid)
    else $error("slot entry waiting but bus idle");

  // rename lands in its register at the edge
  a_rename_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (rename_valid && !flush) |=> cdb_valid)
    else $error("rename entry waiting but bus idle");

endmodule

bind writeback_top writeback_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .flush       (flush),
  .rename_valid(rename_valid),
  .csr_valid   (csr_valid),
  .alu0_valid  (alu0_valid),
  .cdb_valid   (cdb_valid),
  .slot_valid  (slot_valid),
  .slot_stall  (slot_stall),
  .slot_pkt    (slot_pkt)
);

// ==== design/writeback_top.sv ====
/* writeback stage top */
module writeback_top
  import cdb_pkg::*;
#(
  parameter int NUM_CSR = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush,
  input  logic        rename_valid,
  input  rename_pkt_t rename_pkt,
  input  logic        alu0_valid,
  input  alu_issue_t  alu0_issue,
  output logic        alu0_stall,
  input  logic        alu1_valid,
  input  alu_issue_t  alu1_issue,
  output logic        alu1_stall,
  input  logic        csr_valid,
  input  csr_issue_t  csr_issue,
  input  logic        mc0_valid,
  input  cdb_pkt_t    mc0_pkt,
  output logic        mc0_stall,
  input  logic        mc1_valid,
  input  cdb_pkt_t    mc1_pkt,
  output logic        mc1_stall,
  input  logic        lsq_valid,
  input  cdb_pkt_t    lsq_pkt,
  output logic        lsq_stall,
  output logic        cdb_valid,
  output cdb_pkt_t    cdb_pkt
);

  // slot order doubles as priority
  localparam int SLOT_LSQ  = 0;
  localparam int SLOT_MC0  = 1;
  localparam int SLOT_MC1  = 2;
  localparam int SLOT_ALU0 = 3;
  localparam int SLOT_ALU1 = 4;

  logic [NUM_SLOTS-1:0] in_valid;
  logic [NUM_SLOTS-1:0] slot_valid;
  logic [NUM_SLOTS-1:0] slot_stall;
  logic [NUM_SLOTS-1:0] grant;
  cdb_pkt_t             in_pkt   [NUM_SLOTS];
  cdb_pkt_t             slot_pkt [NUM_SLOTS];
  cdb_pkt_t             alu0_pkt;
  cdb_pkt_t             alu1_pkt;
  cdb_pkt_t             csr_pkt;
  logic                 csr_accept;

  scalu u_alu0 (.issue(alu0_issue), .pkt(alu0_pkt));
  scalu u_alu1 (.issue(alu1_issue), .pkt(alu1_pkt));

  // CSR shares the alu0 slot and its stall
  assign csr_accept = csr_valid && !slot_stall[SLOT_ALU0];

  csr_unit #(.NUM_CSR(NUM_CSR)) u_csr (
    .clk   (clk),
    .rst_n (rst_n),
    .flush (flush),
    .accept(csr_accept),
    .issue (csr_issue),
    .pkt   (csr_pkt)
  );

  assign in_valid[SLOT_LSQ]  = lsq_valid;
  assign in_valid[SLOT_MC0]  = mc0_valid;
  assign in_valid[SLOT_MC1]  = mc1_valid;
  assign in_valid[SLOT_ALU0] = alu0_valid || csr_valid;
  assign in_valid[SLOT_ALU1] = alu1_valid;

  assign in_pkt[SLOT_LSQ]  = lsq_pkt;
  assign in_pkt[SLOT_MC0]  = mc0_pkt;
  assign in_pkt[SLOT_MC1]  = mc1_pkt;
  assign in_pkt[SLOT_ALU0] = csr_valid ? csr_pkt : alu0_pkt;
  assign in_pkt[SLOT_ALU1] = alu1_pkt;

  for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
    cdb_slot u_slot (
      .clk     (clk),
      .rst_n   (rst_n),
      .flush   (flush),
      .in_valid(in_valid[i]),
      .in_pkt  (in_pkt[i]),
      .grant   (grant[i]),
      .valid   (slot_valid[i]),
      .pkt     (slot_pkt[i]),
      .stall   (slot_stall[i])
    );
  end

  cdb_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .rename_valid(rename_valid),
    .rename_pkt  (rename_pkt),
    .slot_valid  (slot_valid),
    .slot_pkt    (slot_pkt),
    .grant       (grant),
    .cdb_valid   (cdb_valid),
    .cdb_pkt     (cdb_pkt)
  );

  assign lsq_stall  = slot_stall[SLOT_LSQ];
  assign mc0_stall  = slot_stall[SLOT_MC0];
  assign mc1_stall  = slot_stall[SLOT_MC1];
  assign alu0_stall = slot_stall[SLOT_ALU0];
  assign alu1_stall = slot_stall[SLOT_ALU1];

endmodule

// ==== design/cdb_arbiter.sv ====
/* common data bus arbiter */
module cdb_arbiter
  import cdb_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 rename_valid,
  input  rename_pkt_t          rename_pkt,
  input  logic [NUM_SLOTS-1:0] slot_valid,
  input  cdb_pkt_t             slot_pkt [NUM_SLOTS],
  output logic [NUM_SLOTS-1:0] grant,
  output logic                 cdb_valid,
  output cdb_pkt_t             cdb_pkt
);

  logic        rename_valid_q;
  rename_pkt_t rename_pkt_q;
  cdb_pkt_t    rename_cdb;

  // rename never stalls, so it is captured every edge
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      rename_valid_q <= 1'b0;
    end else begin
      rename_valid_q <= rename_valid;
    end
  end

  always_ff @(posedge clk) begin
    rename_pkt_q <= rename_pkt;
  end

  always_comb begin
    rename_cdb.error  = 1'b0;
    rename_cdb.ecause = '0;
    rename_cdb.robid  = rename_pkt_q.robid;
    rename_cdb.rd     = {1'b0, rename_pkt_q.rd};
    rename_cdb.result = {rename_pkt_q.addr, 2'b00};
  end

  always_comb begin
    grant     = '0;
    cdb_valid = 1'b0;
    cdb_pkt   = '0;
    if (rename_valid_q) begin
      cdb_valid = 1'b1;
      cdb_pkt   = rename_cdb;
    end else begin
      // scan from lowest priority so slot 0 lands last
      for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
        if (slot_valid[i]) begin
          grant     = '0;
          grant[i]  = 1'b1;
          cdb_valid = 1'b1;
          cdb_pkt   = slot_pkt[i];
        end
      end
    end
  end

endmodule

// ==== design/cdb_slot.sv ====
/* writeback slot register */
module cdb_slot
  import cdb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush,
  input  logic     in_valid,
  input  cdb_pkt_t in_pkt,
  input  logic     grant,
  output logic     valid,
  output cdb_pkt_t pkt,
  output logic     stall
);

  // waiting entry that lost arbitration this cycle
  assign stall = valid && !grant;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid <= 1'b0;
    end else if (!stall) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      pkt <= in_pkt;
    end
  end

endmodule

// ==== design/csr_unit.sv ====
/* small CSR register file */
module csr_unit
  import cdb_pkg::*;
#(
  parameter int NUM_CSR = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush,
  input  logic       accept,
  input  csr_issue_t issue,
  output cdb_pkt_t   pkt
);

  localparam int IDX_W = (NUM_CSR > 1) ? $clog2(NUM_CSR) : 1;

  logic [XLEN-1:0]  csr_q [NUM_CSR];
  logic             legal;
  logic [IDX_W-1:0] idx;

  assign legal = (issue.addr < NUM_CSR);
  assign idx   = issue.addr[IDX_W-1:0];

  // read returns the value before any write at this edge
  always_comb begin
    pkt.robid  = issue.robid;
    pkt.rd     = issue.rd;
    pkt.error  = !legal;
    pkt.ecause = legal ? '0 : ECAUSE_ILLEGAL_CSR;
    pkt.result = legal ? csr_q[idx] : '0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CSR; i++) begin
        csr_q[i] <= '0;
      end
    end else if (accept && issue.write && legal && !flush) begin
      csr_q[idx] <= issue.wdata;
    end
  end

endmodule

// ==== design/scalu.sv ====
/* single-cycle scalar ALU */
module scalu
  import cdb_pkg::*;
(
  input  alu_issue_t issue,
  output cdb_pkt_t   pkt
);

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic            add_ovf;
  logic            sub_ovf;
  logic [4:0]      shamt;

  assign sum   = issue.a + issue.b;
  assign diff  = issue.a - issue.b;
  assign shamt = issue.b[4:0];

  // same-sign operands, result sign flipped
  assign add_ovf = (issue.a[XLEN-1] == issue.b[XLEN-1]) &&
                   (sum[XLEN-1] != issue.a[XLEN-1]);
  // opposite signs for subtract
  assign sub_ovf = (issue.a[XLEN-1] != issue.b[XLEN-1]) &&
                   (diff[XLEN-1] != issue.a[XLEN-1]);

  always_comb begin
    pkt.error  = 1'b0;
    pkt.ecause = '0;
    pkt.robid  = issue.robid;
    pkt.rd     = issue.rd;
    pkt.result = '0;
    case (issue.op)
      ADD: begin
        pkt.result = sum;
        if (add_ovf) begin
          pkt.error  = 1'b1;
          pkt.ecause = ECAUSE_OVERFLOW;
        end
      end
      SUB: begin
        pkt.result = diff;
        if (sub_ovf) begin
          pkt.error  = 1'b1;
          pkt.ecause = ECAUSE_OVERFLOW;
        end
      end
      AND: pkt.result = issue.a & issue.b;
      OR:  pkt.result = issue.a | issue.b;
      XOR: pkt.result = issue.a ^ issue.b;
      SLT: pkt.result = {{(XLEN-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
      SLL: pkt.result = issue.a << shamt;
      SRL: pkt.result = issue.a >> shamt;
      default: pkt.result = '0;
    endcase
  end

endmodule

// ==== design/cdb_pkg.sv ====
/* common data bus types */
package cdb_pkg;

  localparam int XLEN     = 32;
  localparam int ROBID_W  = 7;
  localparam int RD_W     = 6;
  localparam int ECAUSE_W = 5;

  // slots behind rename, in priority order
  localparam int NUM_SLOTS = 5;

  // causes raised inside the writeback stage
  localparam logic [ECAUSE_W-1:0] ECAUSE_OVERFLOW    = 5'd1;
  localparam logic [ECAUSE_W-1:0] ECAUSE_ILLEGAL_CSR = 5'd2;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL
  } alu_op_e;

  typedef struct packed {
    logic                error;
    logic [ECAUSE_W-1:0] ecause;
    logic [ROBID_W-1:0]  robid;
    logic [RD_W-1:0]     rd;
    logic [XLEN-1:0]     result;
  } cdb_pkt_t;

  // rename result is word aligned, low two bits implied
  typedef struct packed {
    logic [ROBID_W-1:0] robid;
    logic [RD_W-2:0]    rd;
    logic [XLEN-3:0]    addr;
  } rename_pkt_t;

  typedef struct packed {
    alu_op_e            op;
    logic [ROBID_W-1:0] robid;
    logic [RD_W-1:0]    rd;
    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
  } alu_issue_t;

  typedef struct packed {
    logic               write;
    logic [7:0]         addr;
    logic [XLEN-1:0]    wdata;
    logic [ROBID_W-1:0] robid;
    logic [RD_W-1:0]    rd;
  } csr_issue_t;

endpackage
